//--- design/xcvr_rcfg_pkg.sv
/*
  Shared widths, soft CSR offsets and CSR byte types for the reconfiguration front end.
  CSR offsets are 9-bit word addresses below the CSR select bit.
*/
package xcvr_rcfg_pkg;

  localparam int ADDR_BITS   = 10;
  localparam int DATA_WIDTH  = 32;
  localparam int PHY_DATA_W  = 8;
  localparam int CSR_SEL_BIT = 9;
  localparam int PRBS_CNT_W  = 50;

  // Soft CSR register map
  localparam logic [CSR_SEL_BIT-1:0] CSR_CTRL     = 9'h000;
  localparam logic [CSR_SEL_BIT-1:0] CSR_MASK     = 9'h001;
  localparam logic [CSR_SEL_BIT-1:0] CSR_STATUS   = 9'h002;
  localparam logic [CSR_SEL_BIT-1:0] CSR_PRBS_CMD = 9'h003;
  // Seven snapshot bytes each, least significant byte first
  localparam logic [CSR_SEL_BIT-1:0] CSR_ERR_BASE = 9'h010;
  localparam logic [CSR_SEL_BIT-1:0] CSR_BIT_BASE = 9'h020;

  // Control byte, bit 7 down to bit 0
  typedef struct packed {
    logic tx_digitalreset;
    logic tx_analogreset;
    logic rx_digitalreset;
    logic rx_analogreset;
    logic serial_lpbk;
    logic set_locktodata;
    logic set_locktoref;
    logic override_en;
  } ctrl_byte_t;

  typedef struct packed {
    logic [4:0] rsvd;
    logic       clr;
    logic       snap;
    logic       count_en;
  } prbs_cmd_t;

  // One written byte, decoded by offset
  typedef union packed {
    ctrl_byte_t ctrl;
    prbs_cmd_t  prbs;
  } csr_byte_u;

endpackage

//--- design/rcfg_if_split.sv
/*
  Splits the shared 32-bit reconfiguration port into per-channel requests.
  Channel select sits above the 10-bit channel address; unused selects answer 0.
*/
`timescale 1ns/1ps

module rcfg_if_split #(
  parameter int CHANNELS = 2,
  localparam int SEL_BITS = (CHANNELS > 1) ? $clog2(CHANNELS) : 1
) (
  input  logic                                               reconfig_write,
  input  logic                                               reconfig_read,
  input  logic [SEL_BITS+xcvr_rcfg_pkg::ADDR_BITS-1:0]        reconfig_address,
  input  logic [xcvr_rcfg_pkg::DATA_WIDTH-1:0]               reconfig_writedata,
  output logic [xcvr_rcfg_pkg::DATA_WIDTH-1:0]               reconfig_readdata,
  output logic                                               reconfig_waitrequest,

  output logic [CHANNELS-1:0]                                chnl_write,
  output logic [CHANNELS-1:0]                                chnl_read,
  output logic [xcvr_rcfg_pkg::ADDR_BITS-1:0]                chnl_address,
  output logic [xcvr_rcfg_pkg::DATA_WIDTH-1:0]               chnl_writedata,
  input  logic [CHANNELS*xcvr_rcfg_pkg::PHY_DATA_W-1:0]      chnl_readdata,
  input  logic [CHANNELS-1:0]                                chnl_waitrequest
);

  logic [SEL_BITS-1:0] chnl_sel;

  assign chnl_sel       = reconfig_address[xcvr_rcfg_pkg::ADDR_BITS +: SEL_BITS];
  // Address and data fan out to every channel
  assign chnl_address   = reconfig_address[xcvr_rcfg_pkg::ADDR_BITS-1:0];
  assign chnl_writedata = reconfig_writedata;

  // Only the selected channel sees the strobe and drives the response
  always_comb begin
    chnl_write           = '0;
    chnl_read            = '0;
    reconfig_readdata    = '0;
    reconfig_waitrequest = 1'b0;
    for (int i = 0; i < CHANNELS; i++) begin
      if (int'(chnl_sel) == i) begin
        chnl_write[i]        = reconfig_write;
        chnl_read[i]         = reconfig_read;
        reconfig_waitrequest = chnl_waitrequest[i];
        reconfig_readdata[xcvr_rcfg_pkg::PHY_DATA_W-1:0] =
          chnl_readdata[i*xcvr_rcfg_pkg::PHY_DATA_W +: xcvr_rcfg_pkg::PHY_DATA_W];
      end
    end
  end

endmodule

//--- design/prbs_accum.sv
/*
  PRBS error and bit counters. Error pulses must be synchronous to reconfig_clk;
  only the done flag is resynchronized. Clear wins over snapshot.
*/
`timescale 1ns/1ps

module prbs_accum (
  input  logic                                   reconfig_clk,
  input  logic                                   arst_n,
  input  logic                                   prbs_count_en,
  input  logic                                   prbs_snap,
  input  logic                                   prbs_clr,
  input  logic                                   prbs_err_signal,
  input  logic                                   prbs_done_signal,
  output logic [xcvr_rcfg_pkg::PRBS_CNT_W-1:0]   prbs_err_snap,
  output logic [xcvr_rcfg_pkg::PRBS_CNT_W-1:0]   prbs_bit_snap,
  output logic                                   prbs_done_sync
);

  logic [xcvr_rcfg_pkg::PRBS_CNT_W-1:0] err_cnt;
  logic [xcvr_rcfg_pkg::PRBS_CNT_W-1:0] bit_cnt;
  logic                                 done_meta;

  always_ff @(posedge reconfig_clk or negedge arst_n) begin
    if (!arst_n) begin
      err_cnt       <= '0;
      bit_cnt       <= '0;
      prbs_err_snap <= '0;
      prbs_bit_snap <= '0;
    end else if (prbs_clr) begin
      err_cnt       <= '0;
      bit_cnt       <= '0;
      prbs_err_snap <= '0;
      prbs_bit_snap <= '0;
    end else begin
      if (prbs_count_en) begin
        bit_cnt <= bit_cnt + 1'b1;
        err_cnt <= err_cnt + xcvr_rcfg_pkg::PRBS_CNT_W'(prbs_err_signal);
      end
      // Copies the counts as they stood before this edge
      if (prbs_snap) begin
        prbs_err_snap <= err_cnt;
        prbs_bit_snap <= bit_cnt;
      end
    end
  end

  // Two-flop synchronizer for the done flag
  always_ff @(posedge reconfig_clk or negedge arst_n) begin
    if (!arst_n) begin
      done_meta      <= 1'b0;
      prbs_done_sync <= 1'b0;
    end else begin
      done_meta      <= prbs_done_signal;
      prbs_done_sync <= done_meta;
    end
  end

endmodule

//--- design/rcfg_soft_csr.sv
/*
  Soft CSR block. Every access takes 2 cycles, writes land at the ending edge.
  PRBS snapshot and clear are one-cycle pulses and read back as 0.
*/
`timescale 1ns/1ps

module rcfg_soft_csr (
  input  logic                                   reconfig_clk,
  input  logic                                   arst_n,
  input  logic                                   csr_write,
  input  logic                                   csr_read,
  input  logic [xcvr_rcfg_pkg::CSR_SEL_BIT-1:0]  csr_address,
  input  xcvr_rcfg_pkg::csr_byte_u               csr_writedata,
  output logic [xcvr_rcfg_pkg::PHY_DATA_W-1:0]   csr_readdata,
  output logic                                   csr_waitrequest,

  input  logic in_rx_is_lockedtoref, in_rx_is_lockedtodata,
  input  logic in_tx_cal_busy, in_rx_cal_busy, in_avmm_busy,
  input  logic                                   prbs_done_sync,
  input  logic [xcvr_rcfg_pkg::PRBS_CNT_W-1:0]   prbs_err_snap,
  input  logic [xcvr_rcfg_pkg::PRBS_CNT_W-1:0]   prbs_bit_snap,
  input  logic in_rx_prbs_err_clr, in_set_rx_locktoref, in_set_rx_locktodata,
  input  logic in_en_serial_lpbk,
  input  logic in_rx_analogreset, in_rx_digitalreset,
  input  logic in_tx_analogreset, in_tx_digitalreset,

  output logic                                   prbs_count_en,
  output logic                                   prbs_snap,
  output logic                                   prbs_clr,
  output logic out_prbs_err_clr, out_set_rx_locktoref, out_set_rx_locktodata,
  output logic out_en_serial_lpbk,
  output logic out_rx_analogreset, out_rx_digitalreset,
  output logic out_tx_analogreset, out_tx_digitalreset,
  output logic out_tx_cal_busy_mask, out_rx_cal_busy_mask
);

  localparam int SNAP_BYTES = (xcvr_rcfg_pkg::PRBS_CNT_W + 7) / 8;

  xcvr_rcfg_pkg::ctrl_byte_t                  ctrl_q;
  logic [1:0]                                 mask_q;
  logic                                       csr_req;
  logic                                       csr_ack;
  logic                                       csr_wr_en;
  logic [8*SNAP_BYTES-1:0]                    err_ext;
  logic [8*SNAP_BYTES-1:0]                    bit_ext;
  logic [xcvr_rcfg_pkg::CSR_SEL_BIT-1:0]      err_idx;
  logic [xcvr_rcfg_pkg::CSR_SEL_BIT-1:0]      bit_idx;

  // First cycle waits, second cycle completes
  assign csr_req         = csr_write | csr_read;
  assign csr_waitrequest = csr_req & ~csr_ack;
  assign csr_wr_en       = csr_write & csr_ack;

  always_ff @(posedge reconfig_clk or negedge arst_n) begin
    if (!arst_n) begin
      csr_ack       <= 1'b0;
      ctrl_q        <= '0;
      mask_q        <= 2'b11;
      prbs_count_en <= 1'b0;
      prbs_snap     <= 1'b0;
      prbs_clr      <= 1'b0;
    end else begin
      csr_ack   <= csr_req & ~csr_ack;
      prbs_snap <= 1'b0;
      prbs_clr  <= 1'b0;
      if (csr_wr_en) begin
        case (csr_address)
          xcvr_rcfg_pkg::CSR_CTRL: ctrl_q <= csr_writedata.ctrl;
          xcvr_rcfg_pkg::CSR_MASK: mask_q <= csr_writedata[1:0];
          xcvr_rcfg_pkg::CSR_PRBS_CMD: begin
            prbs_count_en <= csr_writedata.prbs.count_en;
            prbs_snap     <= csr_writedata.prbs.snap;
            prbs_clr      <= csr_writedata.prbs.clr;
          end
          default: ;
        endcase
      end
    end
  end

  // Snapshot byte index; addresses below a base wrap to large values
  assign err_ext = (8*SNAP_BYTES)'(prbs_err_snap);
  assign bit_ext = (8*SNAP_BYTES)'(prbs_bit_snap);
  assign err_idx = csr_address - xcvr_rcfg_pkg::CSR_ERR_BASE;
  assign bit_idx = csr_address - xcvr_rcfg_pkg::CSR_BIT_BASE;

  always_comb begin
    csr_readdata = '0;
    case (csr_address)
      xcvr_rcfg_pkg::CSR_CTRL:     csr_readdata = ctrl_q;
      xcvr_rcfg_pkg::CSR_MASK:     csr_readdata = {6'd0, mask_q};
      xcvr_rcfg_pkg::CSR_STATUS:   csr_readdata = {2'd0, prbs_done_sync, in_avmm_busy,
                                                   in_rx_cal_busy, in_tx_cal_busy,
                                                   in_rx_is_lockedtodata, in_rx_is_lockedtoref};
      xcvr_rcfg_pkg::CSR_PRBS_CMD: csr_readdata = {7'd0, prbs_count_en};
      default: begin
        if (int'(err_idx) < SNAP_BYTES) begin
          csr_readdata = err_ext[8*err_idx +: 8];
        end else if (int'(bit_idx) < SNAP_BYTES) begin
          csr_readdata = bit_ext[8*bit_idx +: 8];
        end
      end
    endcase
  end

  // Override replaces the user controls as a group
  assign out_set_rx_locktoref  = ctrl_q.override_en ? ctrl_q.set_locktoref : in_set_rx_locktoref;
  assign out_set_rx_locktodata = ctrl_q.override_en ? ctrl_q.set_locktodata
                                                    : in_set_rx_locktodata;
  assign out_en_serial_lpbk    = ctrl_q.override_en ? ctrl_q.serial_lpbk : in_en_serial_lpbk;
  assign out_rx_analogreset    = ctrl_q.override_en ? ctrl_q.rx_analogreset : in_rx_analogreset;
  assign out_rx_digitalreset   = ctrl_q.override_en ? ctrl_q.rx_digitalreset
                                                    : in_rx_digitalreset;
  assign out_tx_analogreset    = ctrl_q.override_en ? ctrl_q.tx_analogreset : in_tx_analogreset;
  assign out_tx_digitalreset   = ctrl_q.override_en ? ctrl_q.tx_digitalreset
                                                    : in_tx_digitalreset;

  assign out_prbs_err_clr     = prbs_clr | in_rx_prbs_err_clr;
  assign out_tx_cal_busy_mask = mask_q[0];
  assign out_rx_cal_busy_mask = mask_q[1];

endmodule

//--- design/xcvr_rcfg_chnl.sv
/*
  Per-channel router. Address bit 9 low goes to the PHY port with no added latency,
  bit 9 high goes to the soft CSR. Holds this channel's CSR and PRBS accumulator.
*/
`timescale 1ns/1ps

module xcvr_rcfg_chnl (
  input  logic                                   reconfig_clk,
  input  logic                                   arst_n,

  input  logic                                   chnl_write,
  input  logic                                   chnl_read,
  input  logic [xcvr_rcfg_pkg::ADDR_BITS-1:0]    chnl_address,
  input  logic [xcvr_rcfg_pkg::DATA_WIDTH-1:0]   chnl_writedata,
  output logic [xcvr_rcfg_pkg::PHY_DATA_W-1:0]   chnl_readdata,
  output logic                                   chnl_waitrequest,

  // PHY reconfiguration port
  output logic                                   avmm_write,
  output logic                                   avmm_read,
  output logic [xcvr_rcfg_pkg::ADDR_BITS-1:0]    avmm_address,
  output logic [xcvr_rcfg_pkg::PHY_DATA_W-1:0]   avmm_writedata,
  input  logic [xcvr_rcfg_pkg::PHY_DATA_W-1:0]   avmm_readdata,
  input  logic                                   avmm_waitrequest,

  input  logic                                   prbs_err_signal,
  input  logic                                   prbs_done_signal,
  input  logic in_rx_is_lockedtoref, in_rx_is_lockedtodata,
  input  logic in_tx_cal_busy, in_rx_cal_busy, in_avmm_busy,
  input  logic in_rx_prbs_err_clr, in_set_rx_locktoref, in_set_rx_locktodata,
  input  logic in_en_serial_lpbk,
  input  logic in_rx_analogreset, in_rx_digitalreset,
  input  logic in_tx_analogreset, in_tx_digitalreset,

  output logic out_prbs_err_clr, out_set_rx_locktoref, out_set_rx_locktodata,
  output logic out_en_serial_lpbk,
  output logic out_rx_analogreset, out_rx_digitalreset,
  output logic out_tx_analogreset, out_tx_digitalreset,
  output logic out_tx_cal_busy_mask, out_rx_cal_busy_mask
);

  logic                                       csr_sel;
  logic                                       csr_write;
  logic                                       csr_read;
  logic [xcvr_rcfg_pkg::CSR_SEL_BIT-1:0]      csr_address;
  xcvr_rcfg_pkg::csr_byte_u                   csr_writedata;
  logic [xcvr_rcfg_pkg::PHY_DATA_W-1:0]       csr_readdata;
  logic                                       csr_waitrequest;
  logic                                       prbs_count_en;
  logic                                       prbs_snap;
  logic                                       prbs_clr;
  logic [xcvr_rcfg_pkg::PRBS_CNT_W-1:0]       prbs_err_snap;
  logic [xcvr_rcfg_pkg::PRBS_CNT_W-1:0]       prbs_bit_snap;
  logic                                       prbs_done_sync;

  assign csr_sel = chnl_address[xcvr_rcfg_pkg::CSR_SEL_BIT];

  // PHY side stays idle during CSR accesses
  assign avmm_write     = chnl_write & ~csr_sel;
  assign avmm_read      = chnl_read & ~csr_sel;
  assign avmm_address   = chnl_address;
  assign avmm_writedata = chnl_writedata[xcvr_rcfg_pkg::PHY_DATA_W-1:0];

  assign csr_write     = chnl_write & csr_sel;
  assign csr_read      = chnl_read & csr_sel;
  assign csr_address   = chnl_address[xcvr_rcfg_pkg::CSR_SEL_BIT-1:0];
  assign csr_writedata = chnl_writedata[xcvr_rcfg_pkg::PHY_DATA_W-1:0];

  // Response comes from whichever side was addressed
  assign chnl_readdata    = csr_sel ? csr_readdata : avmm_readdata;
  assign chnl_waitrequest = csr_sel ? csr_waitrequest : avmm_waitrequest;

  rcfg_soft_csr i_rcfg_soft_csr (.*);

  prbs_accum i_prbs_accum (.*);

endmodule

//--- design/xcvr_rcfg_top.sv
/*
  Reconfiguration front end for CHANNELS transceiver channels on one shared port.
  PHY accesses follow the PHY waitrequest; soft CSR accesses take 2 cycles.
*/
`timescale 1ns/1ps

module xcvr_rcfg_top #(
  parameter int CHANNELS = 2,
  localparam int SEL_BITS = (CHANNELS > 1) ? $clog2(CHANNELS) : 1,
  localparam int AW = xcvr_rcfg_pkg::ADDR_BITS,
  localparam int PW = xcvr_rcfg_pkg::PHY_DATA_W
) (
  input  logic                                   reconfig_clk,
  input  logic                                   arst_n,

  input  logic                                   reconfig_write,
  input  logic                                   reconfig_read,
  input  logic [SEL_BITS+AW-1:0]                 reconfig_address,
  input  logic [xcvr_rcfg_pkg::DATA_WIDTH-1:0]   reconfig_writedata,
  output logic [xcvr_rcfg_pkg::DATA_WIDTH-1:0]   reconfig_readdata,
  output logic                                   reconfig_waitrequest,

  output logic [CHANNELS-1:0]                    avmm_write,
  output logic [CHANNELS-1:0]                    avmm_read,
  output logic [CHANNELS*AW-1:0]                 avmm_address,
  output logic [CHANNELS*PW-1:0]                 avmm_writedata,
  input  logic [CHANNELS*PW-1:0]                 avmm_readdata,
  input  logic [CHANNELS-1:0]                    avmm_waitrequest,

  input  logic [CHANNELS-1:0] prbs_err_signal, prbs_done_signal,
  input  logic [CHANNELS-1:0] in_rx_is_lockedtoref, in_rx_is_lockedtodata,
  input  logic [CHANNELS-1:0] in_tx_cal_busy, in_rx_cal_busy, in_avmm_busy,
  input  logic [CHANNELS-1:0] in_rx_prbs_err_clr, in_set_rx_locktoref, in_set_rx_locktodata,
  input  logic [CHANNELS-1:0] in_en_serial_lpbk,
  input  logic [CHANNELS-1:0] in_rx_analogreset, in_rx_digitalreset,
  input  logic [CHANNELS-1:0] in_tx_analogreset, in_tx_digitalreset,

  output logic [CHANNELS-1:0] out_prbs_err_clr, out_set_rx_locktoref, out_set_rx_locktodata,
  output logic [CHANNELS-1:0] out_en_serial_lpbk,
  output logic [CHANNELS-1:0] out_rx_analogreset, out_rx_digitalreset,
  output logic [CHANNELS-1:0] out_tx_analogreset, out_tx_digitalreset,
  output logic [CHANNELS-1:0] out_tx_cal_busy_mask, out_rx_cal_busy_mask
);

  logic [CHANNELS-1:0]                   chnl_write;
  logic [CHANNELS-1:0]                   chnl_read;
  logic [AW-1:0]                         chnl_address;
  logic [xcvr_rcfg_pkg::DATA_WIDTH-1:0]  chnl_writedata;
  logic [CHANNELS*PW-1:0]                chnl_readdata;
  logic [CHANNELS-1:0]                   chnl_waitrequest;

  rcfg_if_split #(
    .CHANNELS (CHANNELS)
  ) i_rcfg_if_split (.*);

  for (genvar i = 0; i < CHANNELS; i++) begin : g_chnl
    xcvr_rcfg_chnl i_xcvr_rcfg_chnl (
      .reconfig_clk          (reconfig_clk),
      .arst_n                (arst_n),
      .chnl_write            (chnl_write[i]),            .chnl_read (chnl_read[i]),
      .chnl_address          (chnl_address),
      .chnl_writedata        (chnl_writedata),
      .chnl_readdata         (chnl_readdata[i*PW +: PW]),
      .chnl_waitrequest      (chnl_waitrequest[i]),
      .avmm_write            (avmm_write[i]),            .avmm_read (avmm_read[i]),
      .avmm_address          (avmm_address[i*AW +: AW]),
      .avmm_writedata        (avmm_writedata[i*PW +: PW]),
      .avmm_readdata         (avmm_readdata[i*PW +: PW]),
      .avmm_waitrequest      (avmm_waitrequest[i]),
      .prbs_err_signal       (prbs_err_signal[i]),
      .prbs_done_signal      (prbs_done_signal[i]),
      .in_rx_is_lockedtoref  (in_rx_is_lockedtoref[i]),
      .in_rx_is_lockedtodata (in_rx_is_lockedtodata[i]),
      .in_tx_cal_busy        (in_tx_cal_busy[i]),
      .in_rx_cal_busy        (in_rx_cal_busy[i]),
      .in_avmm_busy          (in_avmm_busy[i]),
      .in_rx_prbs_err_clr    (in_rx_prbs_err_clr[i]),
      .in_set_rx_locktoref   (in_set_rx_locktoref[i]),
      .in_set_rx_locktodata  (in_set_rx_locktodata[i]),
      .in_en_serial_lpbk     (in_en_serial_lpbk[i]),
      .in_rx_analogreset     (in_rx_analogreset[i]),
      .in_rx_digitalreset    (in_rx_digitalreset[i]),
      .in_tx_analogreset     (in_tx_analogreset[i]),
      .in_tx_digitalreset    (in_tx_digitalreset[i]),
      .out_prbs_err_clr      (out_prbs_err_clr[i]),
      .out_set_rx_locktoref  (out_set_rx_locktoref[i]),
      .out_set_rx_locktodata (out_set_rx_locktodata[i]),
      .out_en_serial_lpbk    (out_en_serial_lpbk[i]),
      .out_rx_analogreset    (out_rx_analogreset[i]),
      .out_rx_digitalreset   (out_rx_digitalreset[i]),
      .out_tx_analogreset    (out_tx_analogreset[i]),
      .out_tx_digitalreset   (out_tx_digitalreset[i]),
      .out_tx_cal_busy_mask  (out_tx_cal_busy_mask[i]),
      .out_rx_cal_busy_mask  (out_rx_cal_busy_mask[i])
    );
  end

endmodule

//--- verif/rcfg_checker.sv
/*
  Watches the DUT's PHY ports and control outputs and compares them with the
  values the testbench expects. Keeps the per-test and total error counts.
*/
`timescale 1ns/1ps

module rcfg_checker #(
  parameter int CHANNELS = 2
) (
  input logic                     clk,
  input logic [CHANNELS-1:0]      avmm_write,
  input logic [CHANNELS-1:0]      avmm_read,
  input logic [CHANNELS*10-1:0]   avmm_address,
  input logic [CHANNELS*8-1:0]    avmm_writedata,
  input logic [CHANNELS-1:0] out_prbs_err_clr, out_set_rx_locktoref, out_set_rx_locktodata,
  input logic [CHANNELS-1:0] out_en_serial_lpbk,
  input logic [CHANNELS-1:0] out_rx_analogreset, out_rx_digitalreset,
  input logic [CHANNELS-1:0] out_tx_analogreset, out_tx_digitalreset,
  input logic [CHANNELS-1:0] out_tx_cal_busy_mask, out_rx_cal_busy_mask
);

  int         err_cnt = 0;
  int         test_errs = 0;
  int         pass_cnt = 0;
  int         fail_cnt = 0;
  int         wr_cnt [CHANNELS];
  int         rd_cnt [CHANNELS];
  logic [9:0] wr_addr [CHANNELS];
  logic [7:0] wr_data [CHANNELS];

  // Log every PHY write and read cycle per channel
  always @(negedge clk) begin
    for (int c = 0; c < CHANNELS; c++) begin
      if (avmm_write[c]) begin
        wr_cnt[c]  = wr_cnt[c] + 1;
        wr_addr[c] = avmm_address[c*10 +: 10];
        wr_data[c] = avmm_writedata[c*8 +: 8];
      end
      if (avmm_read[c]) begin
        rd_cnt[c] = rd_cnt[c] + 1;
      end
    end
  end

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERROR %0t ns %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      err_cnt++;
      test_errs++;
    end
  endtask

  task automatic check_at_least(input string name, input logic [63:0] got,
                                input logic [63:0] min);
    if (got < min) begin
      $display("ERROR %0t ns %s got 0x%0h expected at least 0x%0h", $time, name, got, min);
      err_cnt++;
      test_errs++;
    end
  endtask

  task automatic report_fail(input string msg);
    $display("%0t ns: %s", $time, msg);
    err_cnt++;
    test_errs++;
  endtask

  task automatic clear_phy_log();
    for (int c = 0; c < CHANNELS; c++) begin
      wr_cnt[c] = 0;
      rd_cnt[c] = 0;
    end
  endtask

  // A PHY access holds its request through one wait cycle
  task automatic check_phy_cycles(input int wr_chan, input int rd_chan);
    for (int c = 0; c < CHANNELS; c++) begin
      compare($sformatf("avmm_write[%0d] cycles", c), wr_cnt[c], (c == wr_chan) ? 2 : 0);
      compare($sformatf("avmm_read[%0d] cycles", c), rd_cnt[c], (c == rd_chan) ? 2 : 0);
    end
  endtask

  task automatic check_phy_write(input int chan, input logic [9:0] addr, input logic [7:0] data);
    check_phy_cycles(chan, -1);
    compare("avmm_address", wr_addr[chan], addr);
    compare("avmm_writedata", wr_data[chan], data);
  endtask

  // Control byte layout with out_prbs_err_clr in bit 0
  task automatic check_outs(input int c, input logic [7:0] exp_ctrl, input logic [1:0] exp_mask);
    compare("out_* controls", {out_tx_digitalreset[c], out_tx_analogreset[c],
                               out_rx_digitalreset[c], out_rx_analogreset[c],
                               out_en_serial_lpbk[c], out_set_rx_locktodata[c],
                               out_set_rx_locktoref[c], out_prbs_err_clr[c]}, exp_ctrl);
    compare("cal busy masks", {out_rx_cal_busy_mask[c], out_tx_cal_busy_mask[c]}, exp_mask);
  endtask

  task automatic end_test(input int idx, input string name);
    if (test_errs == 0) begin
      pass_cnt++;
      $display("test %0d %s: pass", idx, name);
    end else begin
      fail_cnt++;
      $display("test %0d %s: FAIL with %0d errors", idx, name, test_errs);
    end
    test_errs = 0;
  endtask

  task automatic print_summary();
    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             pass_cnt + fail_cnt, pass_cnt, fail_cnt, err_cnt);
  endtask

endmodule

//--- verif/tb_xcvr_rcfg.sv
/*
  Testbench for the reconfiguration front end with 2 channels. PHY ports answer
  after one wait cycle with address byte XOR channel*0x10.
*/
`timescale 1ns/1ps

module tb_xcvr_rcfg;

  localparam int CH = 2;
  localparam int TIMEOUT = 20;
  localparam int OP_WR = 0, OP_RD = 1, OP_OUTS = 2, OP_STAT = 3, OP_DONE = 4, OP_PRBS = 5;
  localparam int NTESTS = 18;

  typedef struct {
    int          op;
    int          chan;
    logic [9:0]  addr;
    logic [31:0] data;
    logic [31:0] exp;
  } entry_t;

  logic                reconfig_clk, arst_n, reconfig_write, reconfig_read;
  logic [10:0]         reconfig_address;
  logic [31:0]         reconfig_writedata, reconfig_readdata;
  logic                reconfig_waitrequest;
  logic [CH-1:0]       avmm_write, avmm_read, avmm_waitrequest, phy_ack;
  logic [CH*10-1:0]    avmm_address;
  logic [CH*8-1:0]     avmm_writedata, avmm_readdata;
  logic [CH-1:0] prbs_err_signal, prbs_done_signal;
  logic [CH-1:0] in_rx_is_lockedtoref, in_rx_is_lockedtodata;
  logic [CH-1:0] in_tx_cal_busy, in_rx_cal_busy, in_avmm_busy;
  logic [CH-1:0] in_rx_prbs_err_clr, in_set_rx_locktoref, in_set_rx_locktodata;
  logic [CH-1:0] in_en_serial_lpbk, in_rx_analogreset, in_rx_digitalreset;
  logic [CH-1:0] in_tx_analogreset, in_tx_digitalreset;
  logic [CH-1:0] out_prbs_err_clr, out_set_rx_locktoref, out_set_rx_locktodata;
  logic [CH-1:0] out_en_serial_lpbk, out_rx_analogreset, out_rx_digitalreset;
  logic [CH-1:0] out_tx_analogreset, out_tx_digitalreset;
  logic [CH-1:0] out_tx_cal_busy_mask, out_rx_cal_busy_mask;
  logic [31:0]   lfsr = 32'hadfa_b204;
  entry_t        tbl [NTESTS];

  xcvr_rcfg_top #(.CHANNELS(CH)) i_xcvr_rcfg_top (.*);

  rcfg_checker #(.CHANNELS(CH)) i_rcfg_checker (.clk(reconfig_clk), .*);

  initial begin
    reconfig_clk = 1'b0;
    forever #20 reconfig_clk = ~reconfig_clk;
  end

  // PHY port model with one wait cycle per access
  always_ff @(posedge reconfig_clk or negedge arst_n) begin
    if (!arst_n) begin
      phy_ack <= '0;
    end else begin
      phy_ack <= (avmm_write | avmm_read) & ~phy_ack;
    end
  end
  assign avmm_waitrequest = (avmm_write | avmm_read) & ~phy_ack;
  for (genvar c = 0; c < CH; c++) begin : g_phy
    assign avmm_readdata[c*8 +: 8] = avmm_address[c*10 +: 8] ^ 8'(c * 16);
  end

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic abort_run(input string msg);
    $display("%0t ns: %s", $time, msg);
    $display("Simulation failed");
    $finish;
  endtask

  // Starts and ends 2 ns after a rising edge
  task automatic bus_access(input bit wr, input int chan, input logic [9:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int  cyc;
    bit  done;
    cyc = 0;
    done = 0;
    reconfig_address   = {1'(chan), addr};
    reconfig_writedata = wdata;
    reconfig_write     = wr;
    reconfig_read      = !wr;
    while (!done && cyc <= TIMEOUT) begin
      @(negedge reconfig_clk);
      if (!reconfig_waitrequest) begin
        rdata = reconfig_readdata;
        done = 1;
      end
      cyc++;
    end
    if (!done) begin
      abort_run("waitrequest never dropped during a bus access");
    end else begin
      // Soft CSR and PHY model both complete in the second cycle
      i_rcfg_checker.compare("reconfig_waitrequest cycles", cyc, 2);
      @(posedge reconfig_clk);
      #2;
      reconfig_write = 1'b0;
      reconfig_read  = 1'b0;
    end
  endtask

  task automatic read_snap(input int chan, input logic [9:0] base, output logic [63:0] v);
    logic [31:0] rd;
    v = '0;
    for (int b = 0; b < 7; b++) begin
      bus_access(0, chan, base + 10'(b), 0, rd);
      v[8*b +: 8] = rd[7:0];
    end
  endtask

  // Clear, count K error pulses, snapshot twice, clear again
  task automatic prbs_run(input int chan);
    logic [31:0] rd, k;
    logic [63:0] err1, bit1, err2, bit2;
    bus_access(1, chan, 10'h203, 32'h04, rd);
    bus_access(1, chan, 10'h203, 32'h01, rd);
    k = take_bits(4);
    k = k + 1;
    prbs_err_signal[chan] = 1'b1;
    repeat (k) begin
      @(posedge reconfig_clk);
      #2;
    end
    prbs_err_signal[chan] = 1'b0;
    bus_access(1, chan, 10'h203, 32'h00, rd);
    bus_access(1, chan, 10'h203, 32'h02, rd);
    read_snap(chan, 10'h210, err1);
    read_snap(chan, 10'h220, bit1);
    i_rcfg_checker.compare("prbs error snapshot", err1, 64'(k));
    i_rcfg_checker.check_at_least("prbs bit snapshot", bit1, 64'(k));
    bus_access(1, chan, 10'h203, 32'h02, rd);
    read_snap(chan, 10'h210, err2);
    read_snap(chan, 10'h220, bit2);
    i_rcfg_checker.compare("second error snapshot", err2, 64'(k));
    i_rcfg_checker.compare("second bit snapshot", bit2, bit1);
    bus_access(1, chan, 10'h203, 32'h04, rd);
    read_snap(chan, 10'h210, err2);
    read_snap(chan, 10'h220, bit2);
    i_rcfg_checker.compare("error snapshot after clear", err2, 0);
    i_rcfg_checker.compare("bit snapshot after clear", bit2, 0);
  endtask

  task automatic run_entry(input entry_t t);
    logic [31:0] rd, rnd;
    int          tries;
    case (t.op)
      OP_WR: begin
        i_rcfg_checker.clear_phy_log();
        if (!t.addr[9]) begin
          rnd = take_bits(32);
          bus_access(1, t.chan, t.addr, rnd, rd);
          i_rcfg_checker.check_phy_write(t.chan, t.addr, rnd[7:0]);
        end else begin
          bus_access(1, t.chan, t.addr, t.data, rd);
          i_rcfg_checker.check_phy_cycles(-1, -1);
        end
      end
      OP_RD: begin
        i_rcfg_checker.clear_phy_log();
        bus_access(0, t.chan, t.addr, 0, rd);
        i_rcfg_checker.compare("reconfig_readdata", rd, t.exp);
        i_rcfg_checker.check_phy_cycles(-1, t.addr[9] ? -1 : t.chan);
      end
      OP_OUTS: begin
        rnd = take_bits(8);
        {in_tx_digitalreset[t.chan], in_tx_analogreset[t.chan], in_rx_digitalreset[t.chan],
         in_rx_analogreset[t.chan], in_en_serial_lpbk[t.chan], in_set_rx_locktodata[t.chan],
         in_set_rx_locktoref[t.chan], in_rx_prbs_err_clr[t.chan]} = rnd[7:0];
        @(negedge reconfig_clk);
        // Override replaces bits 7..1 while the error clear input always passes
        i_rcfg_checker.check_outs(t.chan, t.exp[0] ? {t.exp[7:1], rnd[0]} : rnd[7:0],
                                  t.data[1:0]);
        @(posedge reconfig_clk);
        #2;
      end
      OP_STAT: begin
        rnd = take_bits(5);
        {in_avmm_busy[t.chan], in_rx_cal_busy[t.chan], in_tx_cal_busy[t.chan],
         in_rx_is_lockedtodata[t.chan], in_rx_is_lockedtoref[t.chan]} = rnd[4:0];
        bus_access(0, t.chan, t.addr, 0, rd);
        i_rcfg_checker.compare("status byte", rd, {27'd0, rnd[4:0]});
      end
      OP_DONE: begin
        prbs_done_signal[t.chan] = 1'b1;
        tries = 0;
        rd = '0;
        while (!rd[5] && tries < TIMEOUT) begin
          bus_access(0, t.chan, t.addr, 0, rd);
          tries++;
        end
        if (!rd[5]) i_rcfg_checker.report_fail("prbs done never showed in the status byte");
        prbs_done_signal[t.chan] = 1'b0;
      end
      default: prbs_run(t.chan);
    endcase
  endtask

  function automatic string op_name(input int op);
    case (op)
      OP_WR:   return "write";
      OP_RD:   return "read";
      OP_OUTS: return "control outputs";
      OP_STAT: return "status";
      OP_DONE: return "prbs done";
      default: return "prbs counts";
    endcase
  endfunction

  initial begin
    arst_n = 1'b0;
    {reconfig_write, reconfig_read, reconfig_address, reconfig_writedata} = '0;
    {prbs_err_signal, prbs_done_signal, in_rx_is_lockedtoref, in_rx_is_lockedtodata} = '0;
    {in_tx_cal_busy, in_rx_cal_busy, in_avmm_busy, in_rx_prbs_err_clr} = '0;
    {in_set_rx_locktoref, in_set_rx_locktodata, in_en_serial_lpbk} = '0;
    {in_rx_analogreset, in_rx_digitalreset, in_tx_analogreset, in_tx_digitalreset} = '0;
    // Read expectations follow the PHY model and the CSR reset values
    tbl[0]  = '{OP_WR,   0, 10'h045, 32'h0,  32'h0};
    tbl[1]  = '{OP_WR,   1, 10'h1f0, 32'h0,  32'h0};
    tbl[2]  = '{OP_RD,   0, 10'h005, 32'h0,  32'h05};
    tbl[3]  = '{OP_RD,   1, 10'h1a3, 32'h0,  32'hb3};
    tbl[4]  = '{OP_OUTS, 0, 10'h000, 32'h3,  32'h0};
    tbl[5]  = '{OP_OUTS, 1, 10'h000, 32'h3,  32'h0};
    tbl[6]  = '{OP_RD,   0, 10'h200, 32'h0,  32'h0};
    tbl[7]  = '{OP_RD,   0, 10'h201, 32'h0,  32'h3};
    tbl[8]  = '{OP_WR,   0, 10'h200, 32'ha5, 32'h0};
    tbl[9]  = '{OP_WR,   0, 10'h201, 32'h02, 32'h0};
    tbl[10] = '{OP_RD,   0, 10'h200, 32'h0,  32'ha5};
    tbl[11] = '{OP_OUTS, 0, 10'h000, 32'h2,  32'ha5};
    tbl[12] = '{OP_OUTS, 1, 10'h000, 32'h3,  32'h0};
    tbl[13] = '{OP_STAT, 1, 10'h202, 32'h0,  32'h0};
    tbl[14] = '{OP_DONE, 1, 10'h202, 32'h0,  32'h0};
    tbl[15] = '{OP_WR,   1, 10'h2ff, 32'h5a, 32'h0};
    tbl[16] = '{OP_RD,   1, 10'h2ff, 32'h0,  32'h0};
    tbl[17] = '{OP_PRBS, 0, 10'h203, 32'h0,  32'h0};
    repeat (2) @(posedge reconfig_clk);
    #2;
    arst_n = 1'b1;
    for (int i = 0; i < NTESTS; i++) begin
      run_entry(tbl[i]);
      i_rcfg_checker.end_test(i, op_name(tbl[i].op));
    end
    prbs_run(1);
    i_rcfg_checker.end_test(NTESTS, "prbs counts channel 1");
    i_rcfg_checker.print_summary();
    if (i_rcfg_checker.err_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- flist.f
design/xcvr_rcfg_pkg.sv
design/rcfg_if_split.sv
design/prbs_accum.sv
design/rcfg_soft_csr.sv
design/xcvr_rcfg_chnl.sv
design/xcvr_rcfg_top.sv
verif/rcfg_checker.sv
verif/tb_xcvr_rcfg.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing -Wno-fatal --top-module tb_xcvr_rcfg \
		-f flist.f --Mdir obj_dir -o tb_sim
	./obj_dir/tb_sim | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log
